// File: verif/mem_trace.txt
# name op src size addr data busy_len exp_mdata   (op W/R/E/P, src 0 pc 1 da 2 sp 3 ea)
# size 0 byte 1 word 2 quad, numbers after size in hex, busy_len ff = random cen
wr_b_even    W 1 0 000100 0000005a 2  00000000
rd_b_even    R 1 0 000100 00000000 2  0000005a
wr_b_odd     W 1 0 000103 000000c3 2  00000000
rd_b_odd     R 1 0 000103 00000000 2  000000c3
wr_w_even    W 1 1 000110 0000beef 2  00000000
rd_w_even    R 1 1 000110 00000000 2  0000beef
wr_w_odd     W 1 1 000121 00001234 3  00000000
rd_w_odd     R 1 1 000121 00000000 3  00001234
wr_q_even    W 1 2 000130 deadbeef 3  00000000
rd_q_even    R 1 2 000130 00000000 3  deadbeef
wr_q_odd     W 1 2 000141 01234567 4  00000000
rd_q_odd     R 1 2 000141 00000000 4  01234567
rd_b_in_quad R 1 0 000131 00000000 2  000000be
iso_fill     W 1 2 000150 11223344 3  00000000
iso_byte     W 1 0 000153 000000a5 2  00000000
iso_check    R 1 2 000150 00000000 3  a5223344
rd_w_of_quad R 1 1 000132 00000000 2  0000dead
src_sp_wr    W 2 2 000160 cafef00d 3  00000000
src_da_rd    R 1 2 000160 00000000 3  cafef00d
src_ea_latch E 3 0 000170 00000000 0  00000000
src_ea_wr    W 3 1 000170 00007e81 2  00000000
src_sp_rd    R 2 1 000170 00000000 2  00007e81
ea_latch_odd E 3 1 000161 00000000 0  00000000
src_ea_rd    R 3 1 000161 00000000 3  0000fef0
cache_first  R 1 2 000130 00000000 3  deadbeef
cache_hit    R 1 2 000130 00000000 0  deadbeef
pc_hold      P 0 1 000110 00000000 2  0000beef
pc_hit       P 0 1 000110 00000000 0  0000beef
rc_wr_q      W 1 2 000180 89abcdef ff 00000000
rc_rd_q      R 1 2 000180 00000000 ff 89abcdef
rc_wr_w      W 1 1 000183 00005a5a ff 00000000
rc_rd_q2     R 1 2 000181 00000000 ff 5a5aabcd
wrap_rd      R 1 1 000910 00000000 2  0000beef

// File: src.f
rtl/mem_pkg.sv
rtl/mem_bus_seq.sv
rtl/mem_lane_align.sv
rtl/mem_word_ram.sv
rtl/mem_subsys.sv
verif/tb_mem_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# builds the memory unit testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_mem_subsys -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" <<< "$out"; then
    exit 0
fi
exit 1

// File: verif/tb_mem_subsys.sv
// ##########################################################################
// trace-driven testbench for the memory access unit
// trace lines come from verif/mem_trace.txt, one access per line
// a busy length of ff in the trace runs that access with random cen gaps
// and skips the length check, data is still compared
// ##########################################################################

`default_nettype none

module tb_mem_subsys;

    localparam int CLK_P    = 40;
    localparam int MAX_WAIT = 40;         // cycles until busy must fall
    localparam int LINE_CYC = 10;         // watchdog budget per trace line

    logic                       clk;
    logic                       rst;
    logic                       cen;
    logic                       wr;
    logic                       inc_pc;
    logic                       da2ea;
    mem_pkg::size_t             size;
    mem_pkg::ea_src_t           src;
    logic [mem_pkg::ADDR_W-1:0] da;
    logic [mem_pkg::ADDR_W-1:0] pc;
    logic [mem_pkg::DATA_W-1:0] xsp;
    logic [mem_pkg::DATA_W-1:0] md;
    logic                       busy;
    logic [mem_pkg::ADDR_W-1:0] ea;
    logic [mem_pkg::DATA_W-1:0] mdata;

    string       t_name[$];
    string       t_op[$];
    logic [1:0]  t_src[$];
    logic [1:0]  t_size[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_data[$];
    logic [31:0] t_len[$];
    logic [31:0] t_exp[$];

    logic [7:0]  model [2048];          // byte image, RAM wraps at 2 KB
    logic [31:0] lcg_state;
    int          n_pass;
    int          n_fail;
    bit          loaded;

    mem_subsys DUT (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .wr     (wr),
        .inc_pc (inc_pc),
        .da2ea  (da2ea),
        .size   (size),
        .src    (src),
        .da     (da),
        .pc     (pc),
        .xsp    (xsp),
        .md     (md),
        .busy   (busy),
        .ea     (ea),
        .mdata  (mdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_P / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int byte_count(input logic [1:0] sz);
        case (sz)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [23:0] a, input logic [1:0] sz);
        logic [31:0] v;
        logic [10:0] ba;
        v = '0;                                  // unused upper bytes read as zero
        for (int k = 0; k < byte_count(sz); k++) begin
            ba = a[10:0] + 11'(k);
            v[8*k +: 8] = model[ba];
        end
        return v;
    endfunction

    task automatic model_write(input logic [23:0] a, input logic [1:0] sz, input logic [31:0] d);
        logic [10:0] ba;
        for (int k = 0; k < byte_count(sz); k++) begin
            ba = a[10:0] + 11'(k);
            model[ba] = d[8*k +: 8];
        end
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        string       line;
        string       nm;
        string       op;
        logic [31:0] v_src;
        logic [31:0] v_size;
        logic [31:0] v_addr;
        logic [31:0] v_data;
        logic [31:0] v_len;
        logic [31:0] v_exp;
        fd = $fopen("verif/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verif/mem_trace.txt");
            n_fail++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 4 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s %s %d %d %h %h %h %h", nm, op, v_src, v_size,
                        v_addr, v_data, v_len, v_exp);
            if (n != 8) begin
                $display("malformed trace line: %s", line);
                n_fail++;
                continue;
            end
            t_name.push_back(nm);
            t_op.push_back(op);
            t_src.push_back(v_src[1:0]);
            t_size.push_back(v_size[1:0]);
            t_addr.push_back(v_addr);
            t_data.push_back(v_data);
            t_len.push_back(v_len);
            t_exp.push_back(v_exp);
        end
        $fclose(fd);
    endtask

    // counts negedges with busy high, optionally toggling cen at random
    task automatic wait_not_busy(input bit rnd, output int cycles, output bit hung);
        logic [31:0] r;
        cycles = 0;
        hung   = 1'b0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            if (cycles > MAX_WAIT) begin
                hung = 1'b1;
                break;
            end
            @(posedge clk);
            if (rnd) begin
                r = lcg_next();
                cen <= r[16];
            end
            @(negedge clk);
        end
    endtask

    task automatic park();
        @(posedge clk);
        cen    <= 1'b1;
        wr     <= 1'b0;
        src    <= mem_pkg::SRC_PC;       // PC source with inc_pc high requests nothing
        inc_pc <= 1'b1;
        da2ea  <= 1'b0;
    endtask

    task automatic run_test(input int i, output bit ok);
        int          cycles;
        bit          hung;
        bit          rnd;
        logic [23:0] a;
        logic [31:0] want;
        ok     = 1'b1;
        hung   = 1'b0;
        cycles = 0;
        a      = t_addr[i][23:0];
        rnd    = (t_len[i] == 32'hff);
        @(posedge clk);
        size <= mem_pkg::size_t'(t_size[i]);
        if (t_op[i] == "E") begin
            da    <= a;
            da2ea <= 1'b1;
            @(posedge clk);
            da2ea <= 1'b0;
            @(negedge clk);
            if (ea !== a) begin
                $display("ERROR %s ea expected %h actual %h", t_name[i], a, ea);
                ok = 1'b0;
            end
        end else if (t_op[i] == "P") begin
            pc     <= a;
            inc_pc <= 1'b1;
            repeat (3) begin
                @(negedge clk);
                if (busy) begin
                    $display("%s: busy rose while inc_pc was high", t_name[i]);
                    ok = 1'b0;
                end
            end
            @(posedge clk);
            inc_pc <= 1'b0;
            wait_not_busy(rnd, cycles, hung);
        end else begin
            wr  <= (t_op[i] == "W");
            src <= mem_pkg::ea_src_t'(t_src[i]);
            da  <= (t_src[i] == 2'd1) ? a : (a ^ 24'h000400);  // only DA may point at a
            xsp <= {8'h5a, (t_src[i] == 2'd2) ? a : (a ^ 24'h000400)};
            md  <= t_data[i];
            wait_not_busy(rnd, cycles, hung);
        end
        if (hung) begin
            $display("%s: busy never fell", t_name[i]);
            ok = 1'b0;
        end else if (t_op[i] != "E") begin
            if (!rnd && 32'(cycles) != t_len[i]) begin
                $display("ERROR %s busy cycles expected %0d actual %0d",
                         t_name[i], t_len[i], cycles);
                ok = 1'b0;
            end
            if (t_op[i] == "W") begin
                model_write(a, t_size[i], t_data[i]);
            end else begin
                want = model_read(a, t_size[i]);
                if (mdata !== t_exp[i]) begin
                    $display("ERROR %s mdata expected %h actual %h", t_name[i], t_exp[i], mdata);
                    ok = 1'b0;
                end
                if (mdata !== want) begin
                    $display("ERROR %s memory image expected %h actual %h", t_name[i], want, mdata);
                    ok = 1'b0;
                end
            end
        end
        park();
    endtask

    task automatic check_reset(output bit ok);
        int cycles;
        bit hung;
        ok = 1'b1;
        @(negedge clk);
        if (busy !== 1'b0 || ea !== '0 || mdata !== '0) begin
            $display("ERROR reset busy/ea/mdata expected 0/0/0 actual %b/%h/%h", busy, ea, mdata);
            ok = 1'b0;
        end
        @(posedge clk);
        src <= mem_pkg::SRC_DA;
        da  <= 24'h000000;
        @(negedge clk);
        if (busy !== 1'b1) begin
            $display("reset: the first read did not raise busy");
            ok = 1'b0;
        end
        wait_not_busy(1'b0, cycles, hung);
        if (hung) begin
            $display("reset: busy never fell");
            ok = 1'b0;
        end
        park();
    endtask

    initial begin
        bit ok;
        rst       = 1'b1;
        cen       = 1'b1;
        wr        = 1'b0;
        inc_pc    = 1'b1;
        da2ea     = 1'b0;
        size      = mem_pkg::SZ_BYTE;
        src       = mem_pkg::SRC_PC;
        da        = '0;
        pc        = '0;
        xsp       = '0;
        md        = '0;
        lcg_state = 32'd5129;
        n_pass    = 0;
        n_fail    = 0;
        read_trace();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_reset(ok);
        $display("%-14s %s", "reset", ok ? "ok" : "FAILED");
        if (ok) n_pass++;
        else n_fail++;
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i, ok);
            $display("%-14s %s", t_name[i], ok ? "ok" : "FAILED");
            if (ok) n_pass++;
            else n_fail++;
        end
        $display("%0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog, budget scales with the trace length
    initial begin
        longint wd_time;
        wait (loaded);
        wd_time = longint'(t_name.size() + 5) * LINE_CYC * CLK_P;
        #(wd_time);
        $display("watchdog expired before the trace finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mem_subsys.sv
// #########################################################################
// memory access unit with its on-chip RAM
// CPU inputs must stay stable while busy is high
// mdata is valid once busy is low after a read
// #########################################################################

`default_nettype none

module mem_subsys (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic                       wr,
    input  logic                       inc_pc,
    input  logic                       da2ea,
    input  mem_pkg::size_t             size,
    input  mem_pkg::ea_src_t           src,
    input  logic [mem_pkg::ADDR_W-1:0] da,
    input  logic [mem_pkg::ADDR_W-1:0] pc,
    input  logic [mem_pkg::DATA_W-1:0] xsp,
    input  logic [mem_pkg::DATA_W-1:0] md,
    output logic                       busy,
    output logic [mem_pkg::ADDR_W-1:0] ea,
    output logic [mem_pkg::DATA_W-1:0] mdata
);

    logic [mem_pkg::ADDR_W-1:0] bus_addr;
    logic [1:0]                 bus_we;
    mem_pkg::beat_t             beat;
    logic                       beat_stb;
    logic                       start_stb;
    logic [1:0]                 lane_be;
    logic [mem_pkg::BUS_W-1:0]  wr_data;
    logic [mem_pkg::BUS_W-1:0]  rd_data;

    mem_bus_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .wr        (wr),
        .inc_pc    (inc_pc),
        .da2ea     (da2ea),
        .size      (size),
        .src       (src),
        .da        (da),
        .pc        (pc),
        .xsp       (xsp),
        .busy      (busy),
        .ea        (ea),
        .bus_addr  (bus_addr),
        .bus_we    (bus_we),
        .bus_rd    (),
        .beat      (beat),
        .beat_stb  (beat_stb),
        .start_stb (start_stb),
        .lane_be   (lane_be)
    );

    mem_lane_align u_align (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .size      (size),
        .md        (md),
        .beat      (beat),
        .beat_stb  (beat_stb),
        .start_stb (start_stb),
        .odd       (bus_addr[0]),  // lsb of the current beat
        .wr        (wr),
        .rd_data   (rd_data),
        .wr_data   (wr_data),
        .lane_be   (lane_be),
        .mdata     (mdata)
    );

    mem_word_ram u_ram (
        .clk   (clk),
        .addr  (bus_addr),
        .we    (bus_we),
        .wdata (wr_data),
        .rdata (rd_data)
    );

endmodule

`default_nettype wire

// File: rtl/mem_word_ram.sv
// #########################################################################
// 16-bit RAM with one write enable per byte lane and combinational read
// only address bits RAM_AW:1 are decoded, so the contents repeat every 2 KB
// bit 1 of we writes the odd byte, data bits 15:8
// #########################################################################

`default_nettype none

module mem_word_ram (
    input  logic                       clk,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [1:0]                 we,
    input  logic [mem_pkg::BUS_W-1:0]  wdata,
    output logic [mem_pkg::BUS_W-1:0]  rdata
);

    logic [mem_pkg::BUS_W-1:0]  mem [mem_pkg::RAM_WORDS];
    logic [mem_pkg::RAM_AW-1:0] widx;

    assign widx = addr[mem_pkg::RAM_AW:1];   // byte address to word index

    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[widx][7:0] <= wdata[7:0];     // even byte
        end
        if (we[1]) begin
            mem[widx][15:8] <= wdata[15:8];
        end
    end

    assign rdata = mem[widx];

endmodule

`default_nettype wire

// File: rtl/mem_lane_align.sv
// #########################################################################
// byte-lane steering between the 32-bit CPU data and the 16-bit bus
// write data of later beats comes from a register loaded on the first beat
// read data is zero-filled above the access size
// #########################################################################

`default_nettype none

module mem_lane_align (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  mem_pkg::size_t             size,
    input  logic [mem_pkg::DATA_W-1:0] md,
    input  mem_pkg::beat_t             beat,
    input  logic                       beat_stb,
    input  logic                       start_stb,
    input  logic                       odd,
    input  logic                       wr,
    input  logic [mem_pkg::BUS_W-1:0]  rd_data,
    output logic [mem_pkg::BUS_W-1:0]  wr_data,
    output logic [1:0]                 lane_be,
    output logic [mem_pkg::DATA_W-1:0] mdata
);

    logic [mem_pkg::DATA_W-9:0] wr_rest;     // bytes left after the first beat
    logic                       odd_q;       // alignment of the whole access
    mem_pkg::beat_t             last_beat;

    always_comb begin
        case (beat)
            2'd0: begin
                if (odd) begin
                    wr_data = {md[7:0], 8'h00};
                    lane_be = 2'b10;
                end else begin
                    wr_data = md[15:0];
                    lane_be = (size == mem_pkg::SZ_BYTE) ? 2'b01 : 2'b11;
                end
            end
            2'd1: begin
                wr_data = wr_rest[15:0];
                lane_be = (size == mem_pkg::SZ_WORD) ? 2'b01 : 2'b11;  // odd word ends here
            end
            default: begin
                wr_data = {8'h00, wr_rest[23:16]};   // top byte of an odd quad
                lane_be = 2'b01;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (cen && start_stb && wr) begin
            wr_rest <= odd ? md[31:8] : {8'h00, md[31:16]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mdata     <= '0;
            odd_q     <= 1'b0;
            last_beat <= 2'd0;
        end else if (cen && beat_stb) begin
            last_beat <= beat;
            if (start_stb) begin
                odd_q <= odd;
            end
            if (!wr) begin
                case (beat)
                    2'd0: begin
                        if (odd) begin
                            mdata <= {24'h0, rd_data[15:8]};
                        end else if (size == mem_pkg::SZ_BYTE) begin
                            mdata <= {24'h0, rd_data[7:0]};
                        end else begin
                            mdata <= {16'h0, rd_data};
                        end
                    end
                    2'd1: begin
                        if (!odd_q) begin
                            mdata[31:16] <= rd_data;
                        end else if (size == mem_pkg::SZ_WORD) begin
                            mdata[15:8] <= rd_data[7:0];
                        end else begin
                            mdata[23:8] <= rd_data;
                        end
                    end
                    default: mdata[31:24] <= rd_data[7:0];
                endcase
            end
        end
    end

    // every later beat follows the previous one of the same access
    a_beat_order: assert property (
        @(posedge clk) disable iff (rst)
        beat_stb && !start_stb |-> beat == mem_pkg::beat_t'(last_beat + 2'd1)
    );

endmodule

`default_nettype wire

// File: rtl/mem_bus_seq.sv
// #########################################################################
// access sequencer, one request cycle followed by one to three bus beats
// a read starts whenever the selected address misses the cached address
// a write needs wr to drop for one cycle before the next write is taken
// a finished write invalidates the cached address
// #########################################################################

`default_nettype none

module mem_bus_seq (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic                       wr,
    input  logic                       inc_pc,
    input  logic                       da2ea,
    input  mem_pkg::size_t             size,
    input  mem_pkg::ea_src_t           src,
    input  logic [mem_pkg::ADDR_W-1:0] da,
    input  logic [mem_pkg::ADDR_W-1:0] pc,
    input  logic [mem_pkg::DATA_W-1:0] xsp,
    output logic                       busy,
    output logic [mem_pkg::ADDR_W-1:0] ea,
    output logic [mem_pkg::ADDR_W-1:0] bus_addr,
    output logic [1:0]                 bus_we,
    output logic                       bus_rd,
    output mem_pkg::beat_t             beat,
    output logic                       beat_stb,
    output logic                       start_stb,
    input  logic [1:0]                 lane_be
);

    mem_pkg::seq_state_t          state;
    logic [mem_pkg::ADDR_W-1:0]   ca;        // cached address
    logic [mem_pkg::ADDR_W-1:0]   nx_addr;
    logic [1:0]                   adelta;    // byte offset of the current beat
    mem_pkg::beat_t               last_idx;
    logic                         odd_acc;
    logic                         fin;
    logic                         wr_done;   // write served, wait for wr to drop
    logic                         wr_req;
    logic                         rd_req;

    always_comb begin
        case (src)
            mem_pkg::SRC_DA: nx_addr = da;
            mem_pkg::SRC_SP: nx_addr = xsp[mem_pkg::ADDR_W-1:0];
            mem_pkg::SRC_EA: nx_addr = ea;
            default:         nx_addr = pc;
        endcase
    end

    // PC reads wait until the PC has settled
    assign rd_req = !wr && (nx_addr != ca) && (!inc_pc || src != mem_pkg::SRC_PC);
    assign wr_req = wr && !wr_done;

    assign busy = (state != mem_pkg::ST_IDLE) || wr_req || rd_req;

    assign odd_acc = ca[0];

    // beats minus one, by size and alignment
    always_comb begin
        case (size)
            mem_pkg::SZ_BYTE: last_idx = 2'd0;
            mem_pkg::SZ_WORD: last_idx = {1'b0, odd_acc};
            default:          last_idx = odd_acc ? mem_pkg::BEAT_MAX : mem_pkg::LAST_BEAT_QUAD;
        endcase
    end

    always_comb begin
        case (beat)
            2'd0:    adelta = 2'd0;
            2'd1:    adelta = odd_acc ? 2'd1 : 2'd2;   // odd start lands on even word
            default: adelta = 2'd3;
        endcase
    end

    assign fin      = (beat == last_idx);
    assign bus_addr = ca + mem_pkg::ADDR_W'(adelta);

    assign beat_stb  = cen && (state != mem_pkg::ST_IDLE);
    assign start_stb = beat_stb && (beat == 2'd0);

    assign bus_rd = (state == mem_pkg::ST_READ);
    assign bus_we = (cen && state == mem_pkg::ST_WRITE) ? lane_be : 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= mem_pkg::ST_IDLE;
            ca      <= '1;      // nothing cached yet
            beat    <= 2'd0;
            ea      <= '0;
            wr_done <= 1'b0;
        end else if (cen) begin
            if (da2ea) begin
                ea <= da;
            end
            if (!wr) begin
                wr_done <= 1'b0;
            end
            case (state)
                mem_pkg::ST_IDLE: begin
                    beat <= 2'd0;
                    if (wr_req) begin
                        ca    <= nx_addr;
                        state <= mem_pkg::ST_WRITE;
                    end else if (rd_req) begin
                        ca    <= nx_addr;
                        state <= mem_pkg::ST_READ;
                    end
                end
                default: begin
                    if (fin) begin
                        state <= mem_pkg::ST_IDLE;
                        beat  <= 2'd0;
                        if (state == mem_pkg::ST_WRITE) begin
                            ca      <= '1;      // mdata no longer matches memory
                            wr_done <= 1'b1;
                        end
                    end else begin
                        beat <= beat + 2'd1;
                    end
                end
            endcase
        end
    end

    // a read beat runs with wr low, a write beat with wr high
    a_rd_we_excl: assert property (
        @(posedge clk) disable iff (rst)
        beat_stb |-> (bus_rd == !wr)
    );

    // the beat counter never runs past the unaligned quad
    a_beat_range: assert property (
        @(posedge clk) disable iff (rst)
        beat <= mem_pkg::BEAT_MAX
    );

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
// #########################################################################
// shared widths and types for the memory access unit
// 24-bit byte addresses on a 16-bit bus, 32-bit CPU data
// the on-chip RAM decodes only RAM_AW word bits, higher bits alias
// #########################################################################

`default_nettype none

package mem_pkg;

    localparam int ADDR_W    = 24;           // byte address
    localparam int BUS_W     = 16;           // bus data
    localparam int DATA_W    = 32;           // CPU data, quad
    localparam int RAM_AW    = 10;           // word address bits in the RAM
    localparam int RAM_WORDS = 2 ** RAM_AW;

    // beat index type, an access never needs more than three beats
    typedef logic [1:0] beat_t;

    localparam beat_t BEAT_MAX       = 2'd2;  // last beat of an unaligned quad
    localparam beat_t LAST_BEAT_QUAD = 2'd1;  // last beat of an aligned quad

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_QUAD = 2'd2
    } size_t;

    // address source for the next access
    typedef enum logic [1:0] {
        SRC_PC = 2'd0,
        SRC_DA = 2'd1,
        SRC_SP = 2'd2,
        SRC_EA = 2'd3
    } ea_src_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_WRITE = 2'd2
    } seq_state_t;

endpackage

`default_nettype wire
